//--- logic/core_pkg.sv
// RV32 instruction format structs, instruction word union and ALU operation enum
package core_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // instruction formats, msb first as in the ISA manual
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rTypeT;

  typedef struct packed {
    logic [11:0] imm12; // sign extended by decode
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iTypeT;

  typedef struct packed {
    logic [19:0] imm20; // lands in bits 31:12
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } uTypeT;

  // one word, read through whichever format the opcode selects
  typedef union packed {
    rTypeT r;
    iTypeT i;
    uTypeT u;
  } instrT;

  // ALU operations
  typedef enum logic [2:0] {
    aluAdd   = 3'd0,
    aluSub   = 3'd1,
    aluAnd   = 3'd2,
    aluOr    = 3'd3,
    aluXor   = 3'd4,
    aluSlt   = 3'd5,
    aluPassB = 3'd6  // lui, operand b straight through
  } aluOpT;

endpackage

//--- logic/core_settings.svh
// data path width and register file size macros
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// data path
////////////////////////////////////////////////////////////////////////////

`define XLEN 32 // integer data path width

////////////////////////////////////////////////////////////////////////////
// integer register file
////////////////////////////////////////////////////////////////////////////

`define REG_COUNT 32 // x0..x31
`define REG_BITS 5   // register index width

`endif

//--- logic/decodeStage.sv
// decode stage: instruction register, format decoding, immediate build, register read
`timescale 1ns/1ps
`include "core_settings.svh"

module decodeStage (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 instrValid,
  input  core_pkg::instrT      instr,
  // register file read ports
  input  logic [`XLEN-1:0]     readDataA,
  input  logic [`XLEN-1:0]     readDataB,
  output logic [`REG_BITS-1:0] readAddrA,
  output logic [`REG_BITS-1:0] readAddrB,
  // to execute
  output logic                 valid,
  output logic                 illegal,
  output logic                 useImm,
  output logic [`REG_BITS-1:0] rs1,
  output logic [`REG_BITS-1:0] rs2,
  output logic [`REG_BITS-1:0] rd,
  output core_pkg::aluOpT      aluOp,
  output logic [`XLEN-1:0]     imm,
  output logic [`XLEN-1:0]     rs1Data,
  output logic [`XLEN-1:0]     rs2Data
);

  import core_pkg::*;

  localparam logic [6:0] opOp    = 7'b0110011; // R-type ALU
  localparam logic [6:0] opOpImm = 7'b0010011; // I-type ALU
  localparam logic [6:0] opLui   = 7'b0110111;

  logic  validD;
  instrT instrD;

  ////////////////////////////////////////////////////////////////////////////
  // decode register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      validD <= 1'b0;
    end else begin
      validD <= instrValid;
    end
  end

  always_ff @(posedge clk) begin
    if (instrValid) begin
      instrD <= instr;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // field decoding
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    illegal = 1'b0;
    useImm  = 1'b0;
    aluOp   = aluAdd;
    imm     = '0;
    rs1     = instrD.r.rs1;
    rs2     = instrD.r.rs2;
    rd      = instrD.r.rd; // same bits in every format
    case (instrD.r.opcode)
      opOp: begin
        case ({instrD.r.funct7, instrD.r.funct3})
          {7'b0000000, 3'b000}: aluOp = aluAdd;
          {7'b0100000, 3'b000}: aluOp = aluSub;
          {7'b0000000, 3'b111}: aluOp = aluAnd;
          {7'b0000000, 3'b110}: aluOp = aluOr;
          {7'b0000000, 3'b100}: aluOp = aluXor;
          {7'b0000000, 3'b010}: aluOp = aluSlt;
          default:              illegal = 1'b1;
        endcase
      end
      opOpImm: begin
        useImm = 1'b1;
        imm    = {{(`XLEN-12){instrD.i.imm12[11]}}, instrD.i.imm12};
        case (instrD.i.funct3)
          3'b000:  aluOp = aluAdd;
          3'b111:  aluOp = aluAnd;
          3'b110:  aluOp = aluOr;
          3'b100:  aluOp = aluXor;
          3'b010:  aluOp = aluSlt;
          default: illegal = 1'b1;
        endcase
      end
      opLui: begin
        useImm = 1'b1;
        rs1    = '0; // no source, keeps forwarding quiet
        aluOp  = aluPassB;
        imm    = {instrD.u.imm20, {(`XLEN-20){1'b0}}};
      end
      default: illegal = 1'b1;
    endcase
  end

  assign valid = validD;

  // register read, write-through in the file covers the writeback slot
  assign readAddrA = rs1;
  assign readAddrB = rs2;
  assign rs1Data   = readDataA;
  assign rs2Data   = readDataB;

endmodule

//--- logic/executeStage.sv
// execute stage: execute register, operand forwarding, ALU, writeback register
`timescale 1ns/1ps
`include "core_settings.svh"

module executeStage (
  input  logic                 clk,
  input  logic                 rst,
  // from decode
  input  logic                 valid,
  input  logic                 illegal,
  input  logic                 useImm,
  input  logic [`REG_BITS-1:0] rs1,
  input  logic [`REG_BITS-1:0] rs2,
  input  logic [`REG_BITS-1:0] rd,
  input  core_pkg::aluOpT      aluOp,
  input  logic [`XLEN-1:0]     imm,
  input  logic [`XLEN-1:0]     rs1Data,
  input  logic [`XLEN-1:0]     rs2Data,
  // writeback / retire
  output logic                 wbValid,
  output logic                 wbIllegal,
  output logic                 wbWrite,
  output logic [`REG_BITS-1:0] wbRd,
  output logic [`XLEN-1:0]     wbData
);

  import core_pkg::*;

  logic                 exValid;
  logic                 exIllegal;
  logic                 exUseImm;
  logic [`REG_BITS-1:0] exRs1;
  logic [`REG_BITS-1:0] exRs2;
  logic [`REG_BITS-1:0] exRd;
  aluOpT                exAluOp;
  logic [`XLEN-1:0]     exImm;
  logic [`XLEN-1:0]     exRs1Data;
  logic [`XLEN-1:0]     exRs2Data;

  logic [`XLEN-1:0]     srcA;
  logic [`XLEN-1:0]     fwdB;
  logic [`XLEN-1:0]     srcB;
  logic                 lessThan;
  logic [`XLEN-1:0]     aluResult;

  ////////////////////////////////////////////////////////////////////////////
  // execute register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      exValid <= 1'b0;
    end else begin
      exValid <= valid;
    end
  end

  always_ff @(posedge clk) begin
    if (valid) begin
      exIllegal <= illegal;
      exUseImm  <= useImm;
      exRs1     <= rs1;
      exRs2     <= rs2;
      exRd      <= rd;
      exAluOp   <= aluOp;
      exImm     <= imm;
      exRs1Data <= rs1Data;
      exRs2Data <= rs2Data;
    end
  end

  // forward from the instruction one ahead, wbWrite already excludes x0
  assign srcA = (wbWrite && (wbRd == exRs1)) ? wbData : exRs1Data;
  assign fwdB = (wbWrite && (wbRd == exRs2)) ? wbData : exRs2Data;
  assign srcB = exUseImm ? exImm : fwdB;

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  assign lessThan = $signed(srcA) < $signed(srcB);

  always_comb begin
    case (exAluOp)
      aluAdd:   aluResult = srcA + srcB;
      aluSub:   aluResult = srcA - srcB;
      aluAnd:   aluResult = srcA & srcB;
      aluOr:    aluResult = srcA | srcB;
      aluXor:   aluResult = srcA ^ srcB;
      aluSlt:   aluResult = {{(`XLEN-1){1'b0}}, lessThan};
      aluPassB: aluResult = srcB;
      default:  aluResult = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // writeback register, drives retire and the register file write
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wbValid   <= 1'b0;
      wbIllegal <= 1'b0;
      wbWrite   <= 1'b0;
    end else begin
      wbValid   <= exValid;
      wbIllegal <= exValid && exIllegal;
      wbWrite   <= exValid && !exIllegal && (exRd != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (exValid) begin
      wbRd   <= exRd;
      wbData <= exIllegal ? '0 : aluResult; // illegal retires zero
    end
  end

endmodule

//--- logic/pipelinedCore.sv
// top level of the integer pipeline: decode, execute and register file wiring
`timescale 1ns/1ps
`include "core_settings.svh"

module pipelinedCore (
  input  logic                 clk,
  input  logic                 rst,
  // instruction strobe, no back-pressure
  input  logic                 instrValid,
  input  core_pkg::instrT      instr,
  // retire port
  output logic                 retireValid,
  output logic                 retireIllegal,
  output logic [`REG_BITS-1:0] retireRd,
  output logic [`XLEN-1:0]     retireData
);

  import core_pkg::*;

  // register file read path
  logic [`REG_BITS-1:0] readAddrA;
  logic [`REG_BITS-1:0] readAddrB;
  logic [`XLEN-1:0]     readDataA;
  logic [`XLEN-1:0]     readDataB;

  // decode to execute
  logic                 valid;
  logic                 illegal;
  logic                 useImm;
  logic [`REG_BITS-1:0] rs1;
  logic [`REG_BITS-1:0] rs2;
  logic [`REG_BITS-1:0] rd;
  aluOpT                aluOp;
  logic [`XLEN-1:0]     imm;
  logic [`XLEN-1:0]     rs1Data;
  logic [`XLEN-1:0]     rs2Data;

  logic                 wbWrite; // legal, valid, rd != x0

  ////////////////////////////////////////////////////////////////////////////
  // stages
  ////////////////////////////////////////////////////////////////////////////

  decodeStage decode (
    .clk, .rst, .instrValid, .instr,
    .readDataA, .readDataB, .readAddrA, .readAddrB,
    .valid, .illegal, .useImm, .rs1, .rs2, .rd, .aluOp,
    .imm, .rs1Data, .rs2Data
  );

  executeStage execute (
    .clk, .rst,
    .valid, .illegal, .useImm, .rs1, .rs2, .rd, .aluOp,
    .imm, .rs1Data, .rs2Data,
    .wbValid   (retireValid),
    .wbIllegal (retireIllegal),
    .wbWrite,
    .wbRd      (retireRd),
    .wbData    (retireData)
  );

  // writeback values double as the retire port
  registerFile regFile (
    .clk, .rst,
    .readAddrA, .readAddrB, .readDataA, .readDataB,
    .writeEnable (wbWrite),
    .writeAddr   (retireRd),
    .writeData   (retireData)
  );

endmodule

//--- logic/registerFile.sv
// integer register file: two read ports, one write port, x0 fixed at zero
`timescale 1ns/1ps
`include "core_settings.svh"

module registerFile (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`REG_BITS-1:0] readAddrA,
  input  logic [`REG_BITS-1:0] readAddrB,
  output logic [`XLEN-1:0]     readDataA,
  output logic [`XLEN-1:0]     readDataB,
  input  logic                 writeEnable,
  input  logic [`REG_BITS-1:0] writeAddr,
  input  logic [`XLEN-1:0]     writeData
);

  logic [`XLEN-1:0] regs [`REG_COUNT];
  logic             writeLive; // enabled and not x0

  assign writeLive = writeEnable && (writeAddr != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeLive) begin
      regs[writeAddr] <= writeData;
    end
  end

  // same-cycle write shows through to the reader
  always_comb begin
    if (writeLive && (writeAddr == readAddrA)) begin
      readDataA = writeData;
    end else begin
      readDataA = regs[readAddrA]; // regs[0] never written
    end
    if (writeLive && (writeAddr == readAddrB)) begin
      readDataB = writeData;
    end else begin
      readDataB = regs[readAddrB];
    end
  end

endmodule

//--- sim.f
+incdir+logic
logic/core_pkg.sv
logic/registerFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/pipelinedCore.sv
tests/core_assertions.sv
tests/core_tb.sv

//--- tests/core_assertions.sv
// bound assertions on retire port timing and rd routing against the instruction strobe
`timescale 1ns/1ps
`include "core_settings.svh"

module core_assertions (
  input logic                 clk,
  input logic                 rst,
  input logic                 instrValid,
  input core_pkg::instrT      instr,
  input logic                 retireValid,
  input logic [`REG_BITS-1:0] retireRd
);

  int failCount = 0; // failures seen, summed into the closing line

  quietAfterReset: assert property (@(posedge clk) $fell(rst) |=> !retireValid)
    else begin
      failCount++;
      $error("retireValid high in the cycle after reset");
    end

  // one retire per strobe, three cycles later
  fixedLatency: assert property (@(posedge clk) disable iff (rst)
                                 retireValid == $past(instrValid, 3))
    else begin
      failCount++;
      $error("retireValid does not follow instrValid by three cycles");
    end

  // rd field of the word taken three edges back
  rdFollowsWord: assert property (@(posedge clk) disable iff (rst)
                                  retireValid |-> retireRd == $past(instr.r.rd, 3))
    else begin
      failCount++;
      $error("retireRd is not the rd field of the word taken three cycles earlier");
    end

endmodule

bind pipelinedCore core_assertions retireChecks (
  .clk, .rst, .instrValid, .instr, .retireValid, .retireRd
);

//--- tests/core_tb.sv
// testbench for the pipelined core: clock, reset, instruction table, retire checks, watchdog
`timescale 1ns/1ps
`include "core_settings.svh"

module core_tb;

  import core_pkg::*;

  localparam int entryCount = 21;
  localparam int passCount  = 2; // back-to-back first, then with random gaps
  localparam int totalCount = entryCount * passCount;
  localparam int watchdogNs = (totalCount * 7 + 40) * 8;

  logic                 clk;
  logic                 rst;
  logic                 instrValid;
  instrT                instr;
  logic                 retireValid;
  logic                 retireIllegal;
  logic [`REG_BITS-1:0] retireRd;
  logic [`XLEN-1:0]     retireData;

  // stimulus table, expected values worked out by hand
  instrT                progWord [entryCount];
  logic [`REG_BITS-1:0] expRd    [entryCount];
  logic [`XLEN-1:0]     expData  [entryCount];
  bit                   expIll   [entryCount];
  int                   filled = 0;

  int          retired     = 0;
  int          mismatches  = 0;
  int          countErrors = 0; // missing or extra retires
  logic [31:0] lfsr;

  pipelinedCore UUT (
    .clk, .rst, .instrValid, .instr,
    .retireValid, .retireIllegal, .retireRd, .retireData
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(watchdogNs);
    $display("timeout: the retire port stopped before all instructions came out");
    $display("Something failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // instruction encoders and the gap generator
  ////////////////////////////////////////////////////////////////////////////

  function automatic instrT encodeR(input logic [6:0] f7, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3,
                                    input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic instrT encodeI(input logic [11:0] imm, input logic [4:0] rs1,
                                    input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic instrT encodeU(input logic [19:0] imm20, input logic [4:0] rd);
    instrT w;
    w.u.imm20  = imm20;
    w.u.rd     = rd;
    w.u.opcode = 7'b0110111; // lui
    return w;
  endfunction

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic pickGap(output int gap);
    gap = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr = lfsrStep(lfsr); // one step per bit
      gap  = gap | (int'(lfsr[0]) << b);
    end
  endtask

  task automatic addEntry(input instrT w, input logic [`REG_BITS-1:0] rd,
                          input logic [`XLEN-1:0] data, input bit ill);
    progWord[filled] = w;
    expRd[filled]    = rd;
    expData[filled]  = data;
    expIll[filled]   = ill;
    filled++;
  endtask

  task automatic loadProgram();
    addEntry(encodeR(7'h00, 5'd0, 5'd0, 3'b000, 5'd5), 5'd5, 32'h0000_0000, 1'b0);
    addEntry(encodeI(12'h005, 5'd0, 3'b000, 5'd1), 5'd1, 32'h0000_0005, 1'b0);
    addEntry(encodeI(12'hffd, 5'd0, 3'b000, 5'd2), 5'd2, 32'hffff_fffd, 1'b0); // -3
    addEntry(encodeR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 32'h0000_0002, 1'b0);
    addEntry(encodeR(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, 32'h0000_0008, 1'b0); // sub
    addEntry(encodeR(7'h00, 5'd2, 5'd1, 3'b111, 5'd6), 5'd6, 32'h0000_0005, 1'b0);
    addEntry(encodeR(7'h00, 5'd2, 5'd1, 3'b110, 5'd7), 5'd7, 32'hffff_fffd, 1'b0);
    addEntry(encodeR(7'h00, 5'd2, 5'd1, 3'b100, 5'd8), 5'd8, 32'hffff_fff8, 1'b0);
    addEntry(encodeR(7'h00, 5'd1, 5'd2, 3'b010, 5'd9), 5'd9, 32'h0000_0001, 1'b0); // -3 < 5
    addEntry(encodeI(12'hfff, 5'd2, 3'b010, 5'd11), 5'd11, 32'h0000_0001, 1'b0);
    addEntry(encodeI(12'h0f0, 5'd8, 3'b111, 5'd13), 5'd13, 32'h0000_00f0, 1'b0);
    addEntry(encodeI(12'h700, 5'd1, 3'b110, 5'd14), 5'd14, 32'h0000_0705, 1'b0);
    addEntry(encodeI(12'hfff, 5'd2, 3'b100, 5'd15), 5'd15, 32'h0000_0002, 1'b0);
    addEntry(encodeU(20'h12345, 5'd16), 5'd16, 32'h1234_5000, 1'b0);
    addEntry(encodeI(12'h678, 5'd16, 3'b000, 5'd16), 5'd16, 32'h1234_5678, 1'b0);
    addEntry(encodeI(12'd100, 5'd1, 3'b000, 5'd0), 5'd0, 32'h0000_0069, 1'b0); // to x0
    addEntry(encodeR(7'h00, 5'd0, 5'd0, 3'b000, 5'd19), 5'd19, 32'h0000_0000, 1'b0);
    addEntry(32'h0000_01ff, 5'd3, 32'h0000_0000, 1'b1); // unknown opcode
    addEntry(encodeR(7'h01, 5'd1, 5'd1, 3'b000, 5'd4), 5'd4, 32'h0000_0000, 1'b1);
    addEntry(encodeI(12'h000, 5'd3, 3'b000, 5'd20), 5'd20, 32'h0000_0002, 1'b0);
    addEntry(encodeI(12'h000, 5'd4, 3'b000, 5'd21), 5'd21, 32'h0000_0008, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks and the retire checker
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkData(input int entry, input logic [`XLEN-1:0] got,
                           input logic [`XLEN-1:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch retireData entry %0d: got 0x%h expected 0x%h", entry, got, exp);
    end
  endtask

  task automatic checkRd(input int entry, input logic [`REG_BITS-1:0] got,
                         input logic [`REG_BITS-1:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch retireRd entry %0d: got 0x%h expected 0x%h", entry, got, exp);
    end
  endtask

  task automatic checkFlag(input int entry, input logic got, input logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch retireIllegal entry %0d: got 0x%h expected 0x%h", entry, got, exp);
    end
  endtask

  // outputs settle after the rising edge, sample in the middle of the cycle
  always @(negedge clk) begin
    if (!rst && retireValid) begin
      if (retired >= totalCount) begin
        countErrors++;
        $display("an instruction retired with none outstanding at %0t", $time);
      end else begin
        checkRd(retired, retireRd, expRd[retired % entryCount]);
        checkData(retired, retireData, expData[retired % entryCount]);
        checkFlag(retired, retireIllegal, expIll[retired % entryCount]);
      end
      retired++;
    end
  end

  initial begin
    int gap;
    rst        = 1'b1;
    instrValid = 1'b0;
    instr      = '0;
    lfsr       = 32'h1ad1;
    loadProgram();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (3) @(negedge clk); // idle, nothing may retire here
    for (int p = 0; p < passCount; p++) begin
      for (int e = 0; e < entryCount; e++) begin
        gap = 0;
        if (p > 0) begin
          pickGap(gap);
        end
        repeat (gap) begin
          @(negedge clk);
          instrValid = 1'b0;
        end
        @(negedge clk);
        instrValid = 1'b1;
        instr      = progWord[e];
      end
    end
    @(negedge clk);
    instrValid = 1'b0;
    for (int w = 0; w < 10 && retired < totalCount; w++) begin
      @(negedge clk);
    end
    if (retired < totalCount) begin
      countErrors++;
      $display("only %0d of %0d instructions retired", retired, totalCount);
    end
    repeat (6) @(negedge clk); // late extra retires
    $display("errors: %0d mismatch, %0d retire count, %0d assertion",
             mismatches, countErrors, UUT.retireChecks.failCount);
    if (mismatches == 0 && countErrors == 0 && UUT.retireChecks.failCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
